/* hw/trace_defs.svh */
`ifndef TRACE_DEFS_SVH
`define TRACE_DEFS_SVH

// retire slots presented per cycle
`define TRACE_ISSUE_WIDTH 2

// queue holds 2**TRACE_QUEUE_AW entries
`define TRACE_QUEUE_AW 4

// distance between the retire pc and the traced pc
`define TRACE_PC_OFFSET 32'd8

// register file address width
`define TRACE_REG_AW 5

// machine word width
`define TRACE_WORD_W 32

`endif

/* hw/trace_pkg.sv */
`include "trace_defs.svh"

package trace_pkg;

    typedef logic [`TRACE_WORD_W-1:0] word_t;

    // register file write as seen at retirement
    typedef struct packed
    {
        logic                     wen;
        logic [`TRACE_REG_AW-1:0] addr;
        word_t                    data;
    } rf_w_t;

    typedef struct packed
    {
        rf_w_t rfw;
        word_t pc;   // pc of the retiring instruction
    } retire_slot_t;

    // queued record, always valid once stored
    typedef struct packed
    {
        logic [`TRACE_REG_AW-1:0] addr;
        word_t                    data;
        word_t                    pc;   // already lowered by the pc offset
    } trace_entry_t;

endpackage

/* hw/retire_compact.sv */
`timescale 1ns/1ps
`include "trace_defs.svh"

module retire_compact
(
    input  trace_pkg::retire_slot_t [`TRACE_ISSUE_WIDTH-1:0] retire,
    output trace_pkg::trace_entry_t [1:0]                    push_entry,
    output logic [1:0]                                       push_count
);

    import trace_pkg::*;

    function automatic trace_entry_t to_entry(input retire_slot_t slot);
        trace_entry_t e;
        e.addr = slot.rfw.addr;
        e.data = slot.rfw.data;
        e.pc   = slot.pc - `TRACE_PC_OFFSET;
        return e;
    endfunction

    trace_entry_t entry_0;
    trace_entry_t entry_1;

    assign entry_0 = to_entry(retire[0]);
    assign entry_1 = to_entry(retire[1]);

    // slot 1 slides down into position 0 when slot 0 is idle
    assign push_entry[0] = retire[0].rfw.wen ? entry_0 : entry_1;
    assign push_entry[1] = entry_1;   // only consumed when both slots write

    always_comb
    begin
        push_count = 2'd0;
        for (int i = 0; i < `TRACE_ISSUE_WIDTH; i++)
        begin
            if (retire[i].rfw.wen)
            begin
                push_count = push_count + 2'd1;
            end
        end
    end

endmodule

/* hw/queue_pointers.sv */
`timescale 1ns/1ps
`include "trace_defs.svh"

module queue_pointers
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic [1:0]                 push_count,
    input  logic                       pop,
    output logic [`TRACE_QUEUE_AW-1:0] tail_addr,
    output logic [`TRACE_QUEUE_AW-1:0] head_addr,
    output logic                       empty,
    output logic                       retire_stall
);

    localparam int AW    = `TRACE_QUEUE_AW;
    localparam int DEPTH = 1 << AW;

    logic [AW-1:0] tail;
    logic [AW-1:0] head;
    logic [AW:0]   count;   // one extra bit so a full queue is distinct from empty

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            tail <= '0;
            head <= '0;
        end
        else
        begin
            tail <= tail + AW'(push_count);   // wraps naturally
            if (pop)
            begin
                head <= head + AW'(1);
            end
        end
    end

    // push and pop may land on the same edge
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            count <= '0;
        end
        else
        begin
            count <= count + (AW+1)'(push_count) - (AW+1)'(pop);
        end
    end

    assign tail_addr    = tail;
    assign head_addr    = head;
    assign empty        = (count == '0);
    assign retire_stall = (count > (AW+1)'(DEPTH - 2));   // room for one more dual retire

endmodule

/* hw/trace_queue_ram.sv */
`timescale 1ns/1ps
`include "trace_defs.svh"

module trace_queue_ram
(
    input  logic                                  clk,
    input  trace_pkg::trace_entry_t [1:0]         push_entry,
    input  logic [1:0]                            push_count,
    input  logic [`TRACE_QUEUE_AW-1:0]            tail_addr,
    input  logic [`TRACE_QUEUE_AW-1:0]            head_addr,
    output trace_pkg::trace_entry_t               head_entry
);

    import trace_pkg::*;

    localparam int AW    = `TRACE_QUEUE_AW;
    localparam int DEPTH = 1 << AW;

    trace_entry_t  mem [DEPTH];
    logic [AW-1:0] tail_next;

    assign tail_next = tail_addr + AW'(1);   // second write wraps with the queue

    always_ff @(posedge clk)
    begin
        if (push_count != 2'd0)
        begin
            mem[tail_addr] <= push_entry[0];
        end
        if (push_count == 2'd2)
        begin
            mem[tail_next] <= push_entry[1];
        end
    end

    // asynchronous read, the pointers say whether it is valid
    assign head_entry = mem[head_addr];

endmodule

/* hw/trace_handshake_fsm.sv */
`timescale 1ns/1ps

module trace_handshake_fsm
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    empty,
    input  trace_pkg::trace_entry_t head_entry,
    input  logic                    trace_ack,
    output logic                    pop,
    output logic                    trace_req,
    output trace_pkg::trace_entry_t trace_out
);

    typedef enum logic [1:0]
    {
        IDLE,
        REQ,
        WAIT_ACK_LOW
    } state_t;

    state_t state;
    state_t state_next;

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
            begin
                if (!empty)
                begin
                    state_next = REQ;
                end
            end
            REQ:
            begin
                if (trace_ack)
                begin
                    state_next = WAIT_ACK_LOW;   // consumer has taken trace_out
                end
            end
            WAIT_ACK_LOW:
            begin
                if (!trace_ack)
                begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    // one pop per delivery, taken as the entry is loaded
    assign pop = (state == IDLE) && !empty;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state     <= IDLE;
            trace_req <= 1'b0;
            trace_out <= '0;
        end
        else
        begin
            state     <= state_next;
            trace_req <= (state_next == REQ);
            if (pop)
            begin
                trace_out <= head_entry;   // only loads in IDLE, so req and ack are both low
            end
        end
    end

endmodule

/* hw/commit_trace.sv */
`timescale 1ns/1ps
`include "trace_defs.svh"

module commit_trace
(
    input  logic                                             clk,
    input  logic                                             reset,
    input  trace_pkg::retire_slot_t [`TRACE_ISSUE_WIDTH-1:0] retire,
    output logic                                             retire_stall,
    output logic                                             trace_req,
    input  logic                                             trace_ack,
    output trace_pkg::trace_entry_t                          trace_out
);

    import trace_pkg::*;

    trace_entry_t [1:0]         push_entry;
    logic [1:0]                 push_count;
    logic [`TRACE_QUEUE_AW-1:0] tail_addr;
    logic [`TRACE_QUEUE_AW-1:0] head_addr;
    logic                       empty;
    logic                       pop;
    trace_entry_t               head_entry;

    retire_compact u_retire_compact
    (
        .retire     (retire),
        .push_entry (push_entry),
        .push_count (push_count)
    );

    queue_pointers u_queue_pointers
    (
        .clk          (clk),
        .reset        (reset),
        .push_count   (push_count),
        .pop          (pop),
        .tail_addr    (tail_addr),
        .head_addr    (head_addr),
        .empty        (empty),
        .retire_stall (retire_stall)
    );

    trace_queue_ram u_trace_queue_ram
    (
        .clk        (clk),
        .push_entry (push_entry),
        .push_count (push_count),
        .tail_addr  (tail_addr),
        .head_addr  (head_addr),
        .head_entry (head_entry)
    );

    trace_handshake_fsm u_trace_handshake_fsm
    (
        .clk        (clk),
        .reset      (reset),
        .empty      (empty),
        .head_entry (head_entry),
        .trace_ack  (trace_ack),
        .pop        (pop),
        .trace_req  (trace_req),
        .trace_out  (trace_out)
    );

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock
#(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 8
)
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset drops on a falling edge, away from the sampling edge
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

/* tb/commit_trace_tb.sv */
`timescale 1ns/1ps
`include "trace_defs.svh"

module commit_trace_tb;

    import trace_pkg::*;

    localparam int GEN_CYCLES = 480;   // 400 random retire cycles plus the directed ones

    logic                                  clk;
    logic                                  reset;
    retire_slot_t [`TRACE_ISSUE_WIDTH-1:0] retire;
    logic                                  retire_stall;
    logic                                  trace_req;
    logic                                  trace_ack;
    trace_entry_t                          trace_out;

    trace_entry_t exp_q[$];   // entries still owed by the DUT, oldest first
    logic [31:0]  stim_rand;
    logic [31:0]  ack_rand;
    logic         slow_consumer;

    tb_clock #(.PERIOD_NS(8), .RESET_CYCLES(8)) u_tb_clock (.clk(clk), .reset(reset));

    commit_trace u_commit_trace
    (
        .clk          (clk),
        .reset        (reset),
        .retire       (retire),
        .retire_stall (retire_stall),
        .trace_req    (trace_req),
        .trace_ack    (trace_ack),
        .trace_out    (trace_out)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // traced record of one enabled slot
    function automatic trace_entry_t expected_entry(input retire_slot_t s);
        trace_entry_t e;
        e.addr = s.rfw.addr;
        e.data = s.rfw.data;
        e.pc   = s.pc - 32'd8;   // traced pc sits 8 below the retire pc
        return e;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_entry(input string name, input trace_entry_t actual,
                               input trace_entry_t expected);
        if (actual !== expected)
        begin
            abort_run($sformatf("Fail %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            abort_run($sformatf("Fail %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // one retire cycle on the falling edge with random payloads
    task automatic retire_cycle(input logic wen0, input logic wen1, output int pushed);
        retire_slot_t                          slot;
        retire_slot_t [`TRACE_ISSUE_WIDTH-1:0] slots;
        logic [1:0]                            wen;
        @(negedge clk);
        wen    = retire_stall ? 2'b00 : {wen1, wen0};   // no writes into a stalled queue
        pushed = 0;
        for (int i = 0; i < `TRACE_ISSUE_WIDTH; i++)
        begin
            slot.rfw.wen  = wen[i];
            stim_rand     = lcg_next(stim_rand);
            slot.rfw.addr = stim_rand[31:27];
            stim_rand     = lcg_next(stim_rand);
            slot.rfw.data = stim_rand;
            stim_rand     = lcg_next(stim_rand);
            slot.pc       = stim_rand;   // low values wrap below zero
            slots[i]      = slot;
            if (wen[i])
            begin
                exp_q.push_back(expected_entry(slot));   // slot 0 lands first
                pushed++;
            end
        end
        retire <= slots;
    endtask

    // idle until everything is delivered and the handshake is at rest
    task automatic wait_drained();
        int n;
        do
        begin
            retire_cycle(1'b0, 1'b0, n);
        end
        while (exp_q.size() != 0 || trace_req || trace_ack);
    endtask

    initial
    begin : stimulus
        int n;
        int held;
        retire        = '0;
        slow_consumer = 1'b0;
        stim_rand     = 32'hdc01;
        @(negedge reset);
        @(negedge clk);
        check_flag("trace_req", trace_req, 1'b0);
        check_flag("retire_stall", retire_stall, 1'b0);
        check_entry("trace_out", trace_out, '0);

        retire_cycle(1'b1, 1'b0, n);   // lone slot 0
        wait_drained();
        retire_cycle(1'b0, 1'b1, n);   // lone slot 1
        wait_drained();
        retire_cycle(1'b1, 1'b1, n);
        retire_cycle(1'b0, 1'b0, n);   // payloads present, nothing enabled
        wait_drained();
        repeat (20) retire_cycle(1'b0, 1'b0, n);

        // consumer holds off while the queue fills past the stall threshold
        slow_consumer <= 1'b1;
        retire_cycle(1'b1, 1'b0, n);
        do
        begin
            retire_cycle(1'b0, 1'b0, n);
        end
        while (!trace_req);
        held = 0;
        do
        begin
            stim_rand = lcg_next(stim_rand);
            retire_cycle(stim_rand[29] | stim_rand[30], !stim_rand[29], n);
            check_flag("retire_stall", retire_stall, held > 14);
            held += n;
        end
        while (held <= 14);
        repeat (8)
        begin
            retire_cycle(1'b1, 1'b1, n);
            check_flag("retire_stall", retire_stall, 1'b1);
        end
        slow_consumer <= 1'b0;
        wait_drained();
        check_flag("retire_stall", retire_stall, 1'b0);

        repeat (400)
        begin
            stim_rand = lcg_next(stim_rand);
            retire_cycle(stim_rand[31:30] == 2'b00, stim_rand[29:28] == 2'b00, n);
        end
        wait_drained();
        repeat (20) retire_cycle(1'b0, 1'b0, n);

        $display("ALL TESTS PASSED");
        $finish;
    end

    initial
    begin : compare
        logic         req_prev;
        logic         ack_seen;
        trace_entry_t held;
        req_prev = 1'b0;
        ack_seen = 1'b0;
        held     = '0;
        forever
        begin
            @(negedge clk);
            if (trace_req && !req_prev)
            begin
                if (trace_ack)
                begin
                    abort_run("trace_req rose again before trace_ack was dropped");
                end
                else if (exp_q.size() == 0)
                begin
                    abort_run("trace_req rose with no trace entry expected");
                end
                else
                begin
                    held     = exp_q.pop_front();
                    check_entry("trace_out", trace_out, held);
                    ack_seen = 1'b0;
                end
            end
            else if (trace_req || trace_ack)
            begin
                check_entry("trace_out", trace_out, held);   // frozen for the whole handshake
            end
            ack_seen = ack_seen | trace_ack;
            if (req_prev && !trace_req && !ack_seen)
            begin
                abort_run("trace_req dropped before trace_ack was raised");
            end
            req_prev = trace_req;
        end
    end

    initial
    begin : ack_responder
        int delay;
        trace_ack = 1'b0;
        ack_rand  = 32'hdc01;
        forever
        begin
            @(negedge clk);
            if (trace_req && !trace_ack)
            begin
                ack_rand = lcg_next(ack_rand);
                delay    = int'(ack_rand[27:24]) % 6;
                repeat (delay) @(negedge clk);
                while (slow_consumer) @(negedge clk);
                trace_ack <= 1'b1;
                while (trace_req) @(negedge clk);
                trace_ack <= 1'b0;
            end
        end
    end

    initial
    begin : watchdog
        repeat (GEN_CYCLES * 200 + 1000) @(posedge clk);
        abort_run($sformatf("timeout, deliveries stalled with %0d entries owed", exp_q.size()));
    end

endmodule

/* compile.f */
+incdir+hw
hw/trace_pkg.sv
hw/retire_compact.sv
hw/queue_pointers.sv
hw/trace_queue_ram.sv
hw/trace_handshake_fsm.sv
hw/commit_trace.sv
tb/tb_clock.sv
tb/commit_trace_tb.sv

/* run.sh */
#!/bin/sh
# build and run the commit trace testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    -f compile.f --top-module commit_trace_tb -o commit_trace_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/commit_trace_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished cleanly"
exit 0
